//--- verilog/mems_pkg.sv
package mems_pkg;

  // dac command fields, msb first on the wire
  localparam int OP_W  = 4;   // opcode nibble
  localparam int CH_W  = 4;   // channel select
  localparam int VAL_W = 12;  // dac code

  localparam int DAC_WORD_W = 24;  // one spi frame
  localparam int ROM_WORD_W = 16;  // channel in [15:12], value in [11:0]

  // trailing don't-care bits of the command, sent as zeros
  localparam int PAD_W = DAC_WORD_W - OP_W - CH_W - VAL_W;

  // setup words sit at the bottom of the pattern rom
  localparam int RESET_ADDR = 0;  // software reset word
  localparam int VREF_ADDR  = 1;  // reference select word

  // control fsm
  typedef enum logic [1:0] {
    ST_IDLE,        // waiting for start
    ST_SOFT_RESET,  // reset command in flight
    ST_VREF_SETUP,  // vref command in flight
    ST_SCAN         // streaming pattern points
  } mems_state_e;

  // dac opcodes, values fixed by the converter
  typedef enum logic [OP_W-1:0] {
    OP_WRITE_UPDATE = 4'd3,  // write input reg and update output
    OP_RESET        = 4'd7,  // software reset
    OP_VREF         = 4'd8   // internal/external reference setup
  } dac_op_e;

endpackage

//--- verilog/mems_control.sv
`timescale 1ns/1ps

module mems_control (
  input  logic              clk,
  input  logic              mems_soft_reset,
  input  logic              start,            // kicks off the setup sequence
  input  logic              pause,            // holds back the next scan word
  input  logic              spi_busy,
  input  logic              line_end,         // current address closes a line
  input  logic              frame_end,        // current address closes a frame
  input  logic              line_fifo_done,
  input  logic              frame_fifo_done,
  output logic              spi_start,
  output mems_pkg::dac_op_e spi_op,
  output logic              addr_load_reset,
  output logic              addr_load_vref,
  output logic              addr_step,
  output logic              new_line,
  output logic              new_frame
);
  import mems_pkg::*;

  mems_state_e state;
  mems_state_e state_nxt;
  dac_op_e     op_nxt;
  logic        issue;       // launch a command at the next edge
  logic        cmd_ready;   // master idle and no start pending
  logic        scan_word;   // a scan point is being latched this cycle

  // spi_start is the registered copy, busy only rises a cycle after it
  assign cmd_ready = !spi_busy && !spi_start;

  // next state and command issue
  always_comb begin
    state_nxt = state;
    op_nxt    = spi_op;
    issue     = 1'b0;
    case (state)
      ST_IDLE: begin
        if (start) begin
          state_nxt = ST_SOFT_RESET;
          op_nxt    = OP_RESET;
          issue     = 1'b1;
        end
      end
      ST_SOFT_RESET: begin
        if (cmd_ready) begin  // reset word done
          state_nxt = ST_VREF_SETUP;
          op_nxt    = OP_VREF;
          issue     = 1'b1;
        end
      end
      ST_VREF_SETUP: begin
        // first scan point already obeys pause
        if (cmd_ready && !pause) begin
          state_nxt = ST_SCAN;
          op_nxt    = OP_WRITE_UPDATE;
          issue     = 1'b1;
        end
      end
      ST_SCAN: begin
        if (cmd_ready && !pause) begin
          op_nxt = OP_WRITE_UPDATE;
          issue  = 1'b1;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  // counter strobes
  // address is already 0 in idle, the load just pins it
  assign addr_load_reset = (state == ST_IDLE) && start;
  // move the address on while the master latches the current word
  assign addr_load_vref  = spi_start && (spi_op == OP_RESET);
  assign addr_step       = spi_start && (spi_op != OP_RESET);  // vref -> scan base, then +1
  assign scan_word       = spi_start && (spi_op == OP_WRITE_UPDATE);

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      state     <= ST_IDLE;
      spi_start <= 1'b0;
      spi_op    <= OP_RESET;
      new_line  <= 1'b0;
      new_frame <= 1'b0;
    end else begin
      state     <= state_nxt;
      spi_start <= issue;   // one-cycle strobe
      spi_op    <= op_nxt;

      // sticky flags, set beats clear
      if (scan_word && line_end) begin
        new_line <= 1'b1;
      end else if (line_fifo_done) begin
        new_line <= 1'b0;
      end

      if (scan_word && frame_end) begin
        new_frame <= 1'b1;
      end else if (frame_fifo_done) begin
        new_frame <= 1'b0;
      end
    end
  end

endmodule

//--- verilog/scan_addr_counter.sv
`timescale 1ns/1ps

module scan_addr_counter #(
  parameter int ROM_DEPTH       = 72,
  parameter int SCAN_BASE       = 8,
  parameter int LINE_LEN        = 8,
  parameter int LINES_PER_FRAME = 4
) (
  input  logic                         clk,
  input  logic                         mems_soft_reset,
  input  logic                         load_reset,   // point at reset command word
  input  logic                         load_vref,    // point at vref command word
  input  logic                         step,         // advance to the next scan point
  output logic [$clog2(ROM_DEPTH)-1:0] addr,
  output logic                         line_end,
  output logic                         frame_end
);
  import mems_pkg::*;

  localparam int ADDR_W = $clog2(ROM_DEPTH);
  localparam int PT_W   = (LINE_LEN > 1) ? $clog2(LINE_LEN) : 1;
  localparam int LN_W   = (LINES_PER_FRAME > 1) ? $clog2(LINES_PER_FRAME) : 1;

  localparam logic [ADDR_W-1:0] BASE_A  = ADDR_W'(SCAN_BASE);
  localparam logic [ADDR_W-1:0] LAST_A  = ADDR_W'(ROM_DEPTH - 1);
  localparam logic [PT_W-1:0]   LAST_PT = PT_W'(LINE_LEN - 1);
  localparam logic [LN_W-1:0]   LAST_LN = LN_W'(LINES_PER_FRAME - 1);

  logic [PT_W-1:0] pt_cnt;   // point within line
  logic [LN_W-1:0] ln_cnt;   // line within frame
  logic            in_scan;  // address past the setup words

  assign in_scan   = (addr >= BASE_A);
  assign line_end  = in_scan && (pt_cnt == LAST_PT);
  assign frame_end = line_end && (ln_cnt == LAST_LN);

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      addr   <= '0;
      pt_cnt <= '0;
      ln_cnt <= '0;
    end else if (load_reset) begin
      addr   <= ADDR_W'(RESET_ADDR);
      pt_cnt <= '0;
      ln_cnt <= '0;
    end else if (load_vref) begin
      addr   <= ADDR_W'(VREF_ADDR);
      pt_cnt <= '0;
      ln_cnt <= '0;
    end else if (step) begin
      if (!in_scan || addr == LAST_A) begin
        // entering scan region or wrapping, region is whole frames
        addr   <= BASE_A;
        pt_cnt <= '0;
        ln_cnt <= '0;
      end else begin
        addr <= addr + 1'b1;
        if (pt_cnt == LAST_PT) begin
          pt_cnt <= '0;
          ln_cnt <= (ln_cnt == LAST_LN) ? '0 : ln_cnt + 1'b1;  // next line or next frame
        end else begin
          pt_cnt <= pt_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- verilog/scan_rom.sv
`timescale 1ns/1ps

module scan_rom #(
  parameter int ROM_DEPTH = 72
) (
  input  logic                               clk,
  input  logic [$clog2(ROM_DEPTH)-1:0]       addr,
  output logic [mems_pkg::ROM_WORD_W-1:0]    data
);
  import mems_pkg::*;

  // setup words at 0 and 1, scan points from the scan base up
  logic [ROM_WORD_W-1:0] mem [ROM_DEPTH];

  initial begin
    $readmemh("scan_pattern.hex", mem);
  end

  // registered read, one cycle latency
  always_ff @(posedge clk) begin
    data <= mem[addr];
  end

endmodule

//--- verilog/dac_spi_master.sv
`timescale 1ns/1ps

module dac_spi_master #(
  parameter int SPI_DIV = 2  // clocks per sclk half period
) (
  input  logic                            clk,
  input  logic                            mems_soft_reset,
  input  logic                            start,
  input  mems_pkg::dac_op_e               op,
  input  logic [mems_pkg::ROM_WORD_W-1:0] rom_data,
  output logic                            busy,
  output logic                            sclk,
  output logic                            mosi,
  output logic                            cs_n
);
  import mems_pkg::*;

  localparam int DIV_W = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
  localparam int BIT_W = $clog2(DAC_WORD_W);

  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_DIV - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(DAC_WORD_W - 1);

  logic [DAC_WORD_W-1:0] cmd_word;   // assembled command
  logic [DAC_WORD_W-1:0] shreg;      // msb goes out first
  logic [DIV_W-1:0]      div_cnt;
  logic [BIT_W-1:0]      bit_cnt;    // bits already clocked
  logic                  half_done;  // end of an sclk half period
  logic                  accept;

  // opcode | channel | value | pad
  assign cmd_word  = {op, rom_data[ROM_WORD_W-1 -: CH_W], rom_data[VAL_W-1:0],
                      {PAD_W{1'b0}}};
  assign accept    = start && !busy;  // starts while busy are dropped
  assign half_done = (div_cnt == DIV_LAST);
  assign mosi      = shreg[DAC_WORD_W-1] & ~cs_n;  // low outside a frame

  // data path
  always_ff @(posedge clk) begin
    if (accept) begin
      shreg <= cmd_word;
    end else if (!cs_n && half_done && sclk) begin
      shreg <= shreg << 1;  // next bit on the falling edge
    end
  end

  // framing, divider and bit count
  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      busy    <= 1'b0;
      cs_n    <= 1'b1;
      sclk    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (accept) begin
        busy    <= 1'b1;
        cs_n    <= 1'b0;  // msb already on mosi
        sclk    <= 1'b0;
        div_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (cs_n) begin
      busy <= 1'b0;  // tail cycle after cs_n rose
    end else if (half_done) begin
      div_cnt <= '0;
      sclk    <= ~sclk;
      if (sclk) begin  // falling edge closes a bit period
        if (bit_cnt == BIT_LAST) begin
          cs_n <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

//--- verilog/mems_scan_top.sv
`timescale 1ns/1ps

module mems_scan_top #(
  parameter int ROM_DEPTH       = 72,
  parameter int SCAN_BASE       = 8,   // first scan word, above the setup words
  parameter int LINE_LEN        = 8,   // points per line
  parameter int LINES_PER_FRAME = 4,
  parameter int SPI_DIV         = 2    // sclk half period in clocks
) (
  input  logic                         clk,
  input  logic                         mems_soft_reset,
  input  logic                         start,
  input  logic                         pause,
  input  logic                         line_fifo_done,
  input  logic                         frame_fifo_done,
  output logic                         dac_sclk,
  output logic                         dac_mosi,
  output logic                         dac_cs_n,
  output logic                         new_line,
  output logic                         new_frame,
  output logic [$clog2(ROM_DEPTH)-1:0] scan_addr
);
  import mems_pkg::*;

  logic                  spi_start;
  dac_op_e               spi_op;
  logic                  spi_busy;
  logic                  addr_load_reset;
  logic                  addr_load_vref;
  logic                  addr_step;
  logic                  line_end;
  logic                  frame_end;
  logic [ROM_WORD_W-1:0] rom_data;

  // sequencing and flags
  mems_control u_control (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .start           (start),
    .pause           (pause),
    .spi_busy        (spi_busy),
    .line_end        (line_end),
    .frame_end       (frame_end),
    .line_fifo_done  (line_fifo_done),
    .frame_fifo_done (frame_fifo_done),
    .spi_start       (spi_start),
    .spi_op          (spi_op),
    .addr_load_reset (addr_load_reset),
    .addr_load_vref  (addr_load_vref),
    .addr_step       (addr_step),
    .new_line        (new_line),
    .new_frame       (new_frame)
  );

  // address also visible outside
  scan_addr_counter #(
    .ROM_DEPTH       (ROM_DEPTH),
    .SCAN_BASE       (SCAN_BASE),
    .LINE_LEN        (LINE_LEN),
    .LINES_PER_FRAME (LINES_PER_FRAME)
  ) u_addr (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .load_reset      (addr_load_reset),
    .load_vref       (addr_load_vref),
    .step            (addr_step),
    .addr            (scan_addr),
    .line_end        (line_end),
    .frame_end       (frame_end)
  );

  scan_rom #(
    .ROM_DEPTH (ROM_DEPTH)
  ) u_rom (
    .clk  (clk),
    .addr (scan_addr),
    .data (rom_data)
  );

  dac_spi_master #(
    .SPI_DIV (SPI_DIV)
  ) u_spi (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .start           (spi_start),
    .op              (spi_op),
    .rom_data        (rom_data),
    .busy            (spi_busy),
    .sclk            (dac_sclk),
    .mosi            (dac_mosi),
    .cs_n            (dac_cs_n)
  );

endmodule

//--- dv/dac_spi_monitor.sv
`timescale 1ns/1ps

module dac_spi_monitor (
  input  logic                                 clk,
  input  logic                                 mems_soft_reset,
  input  logic                                 sclk,
  input  logic                                 mosi,
  input  logic                                 cs_n,
  output logic [mems_pkg::DAC_WORD_W-1:0]      word,        // last complete frame
  output logic                                 word_valid,  // one cycle per frame
  output logic [$clog2(mems_pkg::DAC_WORD_W):0] bit_count   // bits seen in that frame
);
  import mems_pkg::*;

  logic                          sclk_q;
  logic                          cs_q;
  logic [DAC_WORD_W-1:0]         shift;
  logic [$clog2(DAC_WORD_W):0]   nbits;

  // everything sampled on clk, pins only change on clk edges
  always @(posedge clk) begin
    if (mems_soft_reset) begin
      sclk_q     <= 1'b0;
      cs_q       <= 1'b1;  // an aborted frame is dropped
      shift      <= '0;
      nbits      <= '0;
      word       <= '0;
      word_valid <= 1'b0;
      bit_count  <= '0;
    end else begin
      sclk_q     <= sclk;
      cs_q       <= cs_n;
      word_valid <= 1'b0;
      if (!cs_n && cs_q) begin
        shift <= '0;  // frame opens
        nbits <= '0;
      end else if (!cs_n && sclk && !sclk_q) begin
        shift <= {shift[DAC_WORD_W-2:0], mosi};  // msb first, taken at sclk rise
        nbits <= nbits + 1'b1;
      end
      if (cs_n && !cs_q) begin
        word       <= shift;  // frame closed
        bit_count  <= nbits;
        word_valid <= 1'b1;
      end
    end
  end

endmodule

//--- dv/tb_mems_scan.sv
`timescale 1ns/1ps

module tb_mems_scan;
  import mems_pkg::*;

  localparam int ROM_DEPTH       = 72;
  localparam int SCAN_BASE       = 8;
  localparam int LINE_LEN        = 8;
  localparam int LINES_PER_FRAME = 4;
  localparam int SPI_DIV         = 2;
  localparam int SCAN_LEN        = ROM_DEPTH - SCAN_BASE;  // points per pass
  localparam int FRAME_LEN       = LINE_LEN * LINES_PER_FRAME;
  localparam int WORD_CYCLES     = DAC_WORD_W * 2 * SPI_DIV + 8;     // frame plus slack
  localparam int LIMIT_CYCLES    = 3 * SCAN_LEN * WORD_CYCLES + 20000;  // pauses in margin

  logic clk = 1'b0;
  logic mems_soft_reset;
  logic start;
  logic pause;
  logic line_fifo_done;
  logic frame_fifo_done;
  logic dac_sclk;
  logic dac_mosi;
  logic dac_cs_n;
  logic new_line;
  logic new_frame;
  logic [$clog2(ROM_DEPTH)-1:0] scan_addr;
  logic [DAC_WORD_W-1:0]        mon_word;
  logic                         mon_valid;
  logic [$clog2(DAC_WORD_W):0]  mon_bits;
  logic [ROM_WORD_W-1:0]        pattern [ROM_DEPTH];  // reference copy of the rom
  logic [31:0] rng_state = 32'h653fab85;
  int words_done = 0;      // decoded frames since start
  int frames_started = 0;  // cs_n falls since start
  int word_errs = 0;
  int flag_errs = 0;
  int seq_errs = 0;
  logic idle_phase = 1'b1;
  logic cs_q = 1'b1;
  logic nl_q = 1'b0;
  logic nf_q = 1'b0;
  logic pause_q = 1'b0;
  logic pause_qq = 1'b0;
  logic line_done_q = 1'b0;
  logic frame_done_q = 1'b0;
  logic rst_q = 1'b0;

  mems_scan_top #(
    .ROM_DEPTH (ROM_DEPTH), .SCAN_BASE (SCAN_BASE), .LINE_LEN (LINE_LEN),
    .LINES_PER_FRAME (LINES_PER_FRAME), .SPI_DIV (SPI_DIV)
  ) uut (
    .clk (clk), .mems_soft_reset (mems_soft_reset), .start (start), .pause (pause),
    .line_fifo_done (line_fifo_done), .frame_fifo_done (frame_fifo_done),
    .dac_sclk (dac_sclk), .dac_mosi (dac_mosi), .dac_cs_n (dac_cs_n),
    .new_line (new_line), .new_frame (new_frame), .scan_addr (scan_addr)
  );

  dac_spi_monitor u_mon (
    .clk (clk), .mems_soft_reset (mems_soft_reset), .sclk (dac_sclk), .mosi (dac_mosi),
    .cs_n (dac_cs_n), .word (mon_word), .word_valid (mon_valid), .bit_count (mon_bits)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    rng_state = xorshift32(rng_state);
    return lo + int'(rng_state % (hi - lo + 1));
  endfunction

  // n-th frame after start is reset word, vref word, then scan points with wrap
  function automatic logic [DAC_WORD_W-1:0] expected_word(input int n);
    logic [ROM_WORD_W-1:0] rw;
    dac_op_e               op;
    if (n == 0) begin
      op = OP_RESET;
      rw = pattern[RESET_ADDR];
    end else if (n == 1) begin
      op = OP_VREF;
      rw = pattern[VREF_ADDR];
    end else begin
      op = OP_WRITE_UPDATE;
      rw = pattern[SCAN_BASE + (n - 2) % SCAN_LEN];
    end
    return {op, rw[15:12], rw[11:0], 4'h0};  // opcode, channel, value, pad
  endfunction

  always @(posedge clk) begin : check
    logic cs_fall;
    logic line_set;
    logic frame_set;
    int   idx;
    cs_fall   = cs_q && !dac_cs_n;
    idx       = frames_started - 2;  // scan index of the word now starting
    line_set  = cs_fall && frames_started >= 2 && idx % LINE_LEN == LINE_LEN - 1;
    frame_set = cs_fall && frames_started >= 2 && idx % FRAME_LEN == FRAME_LEN - 1;
    if (mems_soft_reset) begin
      frames_started <= 0;
      words_done     <= 0;
    end else begin
      if (rst_q) begin  // first cycle out of reset
        assert (dac_cs_n && !dac_sclk && !new_line && !new_frame && scan_addr == 0)
          else begin
            seq_errs++;
            $write("[ERROR] after reset: dac_cs_n=%h dac_sclk=%h new_line=%h",
                   dac_cs_n, dac_sclk, new_line);
            $display(" new_frame=%h scan_addr=%h", new_frame, scan_addr);
          end
      end
      if (idle_phase) begin
        assert (dac_cs_n && !new_line && !new_frame)
          else begin
            seq_errs++;
            $display("SPI frame or scan flag appeared before start");
          end
      end
      assert ((new_line && !nl_q) == line_set) else begin
        flag_errs++;
        $display("[ERROR] new_line rise=%h expected %h, frame %0d", new_line && !nl_q,
                 line_set, frames_started);
      end
      assert ((new_frame && !nf_q) == frame_set) else begin
        flag_errs++;
        $display("[ERROR] new_frame rise=%h expected %h, frame %0d", new_frame && !nf_q,
                 frame_set, frames_started);
      end
      // sticky until the done strobe
      assert (!nl_q || new_line || line_done_q) else begin
        flag_errs++;
        $display("new_line dropped without its done strobe");
      end
      assert (!nf_q || new_frame || frame_done_q) else begin
        flag_errs++;
        $display("new_frame dropped without its done strobe");
      end
      // done clears next cycle unless a new set lands on it
      assert (!line_done_q || line_set || !new_line) else begin
        flag_errs++;
        $display("[ERROR] new_line = %h after line_fifo_done, expected 0", new_line);
      end
      assert (!frame_done_q || frame_set || !new_frame) else begin
        flag_errs++;
        $display("[ERROR] new_frame = %h after frame_fifo_done, expected 0", new_frame);
      end
      if (cs_fall) begin
        frames_started <= frames_started + 1;
        assert (frames_started < 2 || !pause_qq) else begin
          seq_errs++;
          $display("scan word %0d started while pause was high", idx);
        end
      end
      if (mon_valid) begin
        words_done <= words_done + 1;
        assert (mon_word === expected_word(words_done)) else begin
          word_errs++;
          $display("[ERROR] mon_word #%0d = %h, expected %h", words_done, mon_word,
                   expected_word(words_done));
        end
        assert (mon_bits == DAC_WORD_W) else begin
          word_errs++;
          $display("[ERROR] mon_bits = %h, expected %h", mon_bits, DAC_WORD_W);
        end
      end
    end
    cs_q         <= dac_cs_n;
    nl_q         <= new_line;
    nf_q         <= new_frame;
    pause_q      <= pause;
    pause_qq     <= pause_q;  // pause as the control saw it when issuing
    line_done_q  <= line_fifo_done;
    frame_done_q <= frame_fifo_done;
    rst_q        <= mems_soft_reset;
  end

  task automatic pulse_start();
    start      <= 1'b1;
    idle_phase <= 1'b0;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // run until target frames decoded with random pause windows
  task automatic run_with_pauses(input int target);
    int gap;
    int hold;
    while (words_done < target) begin
      gap = rand_range(100, 900);
      while (gap > 0 && words_done < target) begin
        @(posedge clk);
        gap--;
      end
      if (words_done < target) begin
        hold = rand_range(50, 400);  // often longer than one spi frame
        pause <= 1'b1;
        repeat (hold) @(posedge clk);
        pause <= 1'b0;
      end
    end
  endtask

  // downstream fifo stand-ins clear each flag after a random delay
  initial begin
    forever begin
      @(posedge clk);
      if (new_line === 1'b1) begin
        repeat (rand_range(1, 30)) @(posedge clk);
        line_fifo_done <= 1'b1;
        @(posedge clk);
        line_fifo_done <= 1'b0;
      end
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      if (new_frame === 1'b1) begin
        repeat (rand_range(1, 30)) @(posedge clk);
        frame_fifo_done <= 1'b1;
        @(posedge clk);
        frame_fifo_done <= 1'b0;
      end
    end
  end

  initial begin
    #(LIMIT_CYCLES * 10);
    $display("watchdog expired, the scan did not finish within %0d cycles", LIMIT_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    mems_soft_reset = 1'b1;
    start           = 1'b0;
    pause           = 1'b0;
    line_fifo_done  = 1'b0;
    frame_fifo_done = 1'b0;
    $readmemh("scan_pattern.hex", pattern);
    repeat (4) @(posedge clk);
    mems_soft_reset <= 1'b0;
    repeat (20) @(posedge clk);  // idle so nothing may move yet
    pulse_start();
    run_with_pauses(2 + 2 * SCAN_LEN + 4);  // setup, two passes, past the wrap
    while (dac_cs_n) @(posedge clk);  // land the reset inside a frame
    repeat (rand_range(5, 60)) @(posedge clk);
    mems_soft_reset <= 1'b1;
    idle_phase      <= 1'b1;
    repeat (4) @(posedge clk);
    mems_soft_reset <= 1'b0;
    repeat (10) @(posedge clk);
    pulse_start();
    run_with_pauses(2 + FRAME_LEN + 2);  // restart through a frame boundary
    repeat (20) @(posedge clk);
    $display("errors: words %0d, flags %0d, sequence %0d", word_errs, flag_errs, seq_errs);
    if (word_errs + flag_errs + seq_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- compile.f
verilog/mems_pkg.sv
verilog/mems_control.sv
verilog/scan_addr_counter.sv
verilog/scan_rom.sv
verilog/dac_spi_master.sv
verilog/mems_scan_top.sv
dv/dac_spi_monitor.sv
dv/tb_mems_scan.sv

//--- scan_pattern.hex
// one word per line: channel in [15:12], value in [11:0]
// addr 0 reset word, addr 1 vref word, addr 8 up scan points
F000
0001
0000
0000
0000
0000
0000
0000
0100
1120
0140
1160
0180
11A0
01C0
11E0
0200
1220
0240
1260
0280
12A0
02C0
12E0
0300
1320
0340
1360
0380
13A0
03C0
13E0
0400
1420
0440
1460
0480
14A0
04C0
14E0
0500
1520
0540
1560
0580
15A0
05C0
15E0
0600
1620
0640
1660
0680
16A0
06C0
16E0
0700
1720
0740
1760
0780
17A0
07C0
17E0
0800
1820
0840
1860
0880
18A0
08C0
18E0
